// File: logic/Fp32Unit_config.svh
// Fixed register map, class-mask bit positions and canonical NaN of the FP coprocessor.
`ifndef FP32_UNIT_CONFIG_SVH
`define FP32_UNIT_CONFIG_SVH

// Wishbone word addresses.
`define FP_REG_SRC1   3'd0
`define FP_REG_SRC2   3'd1
`define FP_REG_INTSRC 3'd2
`define FP_REG_CMD    3'd3
`define FP_REG_INTRES 3'd4
`define FP_REG_FPRES  3'd5
`define FP_REG_FLAGS  3'd6

// Bit positions in the FCLASS.S result, in RISC-V order.
`define FP_CLASS_NEG_INF       0
`define FP_CLASS_NEG_NORMAL    1
`define FP_CLASS_NEG_SUBNORMAL 2
`define FP_CLASS_NEG_ZERO      3
`define FP_CLASS_POS_ZERO      4
`define FP_CLASS_POS_SUBNORMAL 5
`define FP_CLASS_POS_NORMAL    6
`define FP_CLASS_POS_INF       7
`define FP_CLASS_SIGNALING_NAN 8
`define FP_CLASS_QUIET_NAN     9

`define FP_CANONICAL_NAN 32'h7fc0_0000

`endif

// File: logic/Fp32Types.sv
// Shared types for the single-precision coprocessor and its Wishbone slave port.
package Fp32Types;

    // Field layout of an IEEE 754 single-precision word.
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] fraction;
    } fp32Fields_t;

    // The ports carry the raw view and the datapaths decode the fields.
    typedef union packed {
        logic [31:0] raw;
        fp32Fields_t field;
    } fp32_t;

    // RISC-V exception flags, nv in bit 4 down to nx in bit 0.
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef enum logic [1:0] {
        FpUnitType_Move       = 2'd0,
        FpUnitType_Classifier = 2'd1,
        FpUnitType_Sign       = 2'd2,
        FpUnitType_Comparator = 2'd3
    } FpUnitType;

    typedef enum logic [1:0] {
        FpSignCommand_Sgnj  = 2'd0,
        FpSignCommand_Sgnjn = 2'd1,
        FpSignCommand_Sgnjx = 2'd2
    } FpSignCommand;

    typedef enum logic [2:0] {
        FpCmpCommand_Eq  = 3'd0,
        FpCmpCommand_Lt  = 3'd1,
        FpCmpCommand_Le  = 3'd2,
        FpCmpCommand_Min = 3'd3,
        FpCmpCommand_Max = 3'd4
    } FpCmpCommand;

    // Seven bits held in the low end of the command register.
    typedef struct packed {
        FpUnitType    unit;
        FpSignCommand sign;
        FpCmpCommand  cmp;
    } FpUnitCommand;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] datW;
    } WbRequest;

    typedef struct packed {
        logic        ack;
        logic [31:0] datR;
    } WbResponse;

endpackage

// File: logic/FpSignUnit.sv
// Sign-injection datapath for FSGNJ.S, FSGNJN.S and FSGNJX.S.
`timescale 1ns/1ps

module FpSignUnit
    import Fp32Types::*;
(
    input  FpSignCommand command,
    input  fp32_t        fpSrc1,
    input  fp32_t        fpSrc2,
    output fp32_t        fpResult
);

    logic newSign;

    always_comb begin
        case (command)
            FpSignCommand_Sgnj: begin
                newSign = fpSrc2.field.sign;
            end
            FpSignCommand_Sgnjn: begin
                newSign = ~fpSrc2.field.sign;
            end
            FpSignCommand_Sgnjx: begin
                newSign = fpSrc1.field.sign ^ fpSrc2.field.sign;
            end
            default: begin
                // Unassigned encoding keeps the operand as it is.
                newSign = fpSrc1.field.sign;
            end
        endcase
    end

    // Exponent and fraction always pass through from the first operand.
    always_comb begin
        fpResult.field.sign     = newSign;
        fpResult.field.exponent = fpSrc1.field.exponent;
        fpResult.field.fraction = fpSrc1.field.fraction;
    end

endmodule

// File: logic/FpComparator.sv
// Single-precision comparator for FEQ, FLT, FLE, FMIN and FMAX with IEEE NaN rules.
`timescale 1ns/1ps
`include "Fp32Unit_config.svh"

module FpComparator
    import Fp32Types::*;
(
    input  FpCmpCommand command,
    input  fp32_t       fpSrc1,
    input  fp32_t       fpSrc2,
    output logic [31:0] intResult,
    output fp32_t       fpResult,
    output fflags_t     flags
);

    logic        nan1;
    logic        nan2;
    logic        sNan1;
    logic        sNan2;
    logic        anyNan;
    logic        anySNan;
    logic        bothZero;
    logic [30:0] magnitude1;
    logic [30:0] magnitude2;
    logic        equal;
    logic        less;
    logic        minLess;
    fp32_t       minMax;

    assign magnitude1 = {fpSrc1.field.exponent, fpSrc1.field.fraction};
    assign magnitude2 = {fpSrc2.field.exponent, fpSrc2.field.fraction};

    assign nan1  = (fpSrc1.field.exponent == 8'hff) && (fpSrc1.field.fraction != '0);
    assign nan2  = (fpSrc2.field.exponent == 8'hff) && (fpSrc2.field.fraction != '0);
    // A NaN with the top fraction bit clear is signaling.
    assign sNan1 = nan1 && !fpSrc1.field.fraction[22];
    assign sNan2 = nan2 && !fpSrc2.field.fraction[22];

    assign anyNan   = nan1 || nan2;
    assign anySNan  = sNan1 || sNan2;
    assign bothZero = (magnitude1 == '0) && (magnitude2 == '0);

    // Plus zero and minus zero are equal for the ordered predicates.
    assign equal = (fpSrc1.raw == fpSrc2.raw) || bothZero;

    always_comb begin
        if (fpSrc1.field.sign != fpSrc2.field.sign) begin
            less = fpSrc1.field.sign && !bothZero;
        end else if (fpSrc1.field.sign) begin
            less = magnitude1 > magnitude2;
        end else begin
            less = magnitude1 < magnitude2;
        end
    end

    // FMIN and FMAX order minus zero below plus zero.
    assign minLess = less || (bothZero && fpSrc1.field.sign && !fpSrc2.field.sign);

    always_comb begin
        if (nan1 && nan2) begin
            minMax.raw = `FP_CANONICAL_NAN;
        end else if (nan1) begin
            minMax = fpSrc2;
        end else if (nan2) begin
            minMax = fpSrc1;
        end else if (command == FpCmpCommand_Min) begin
            minMax = minLess ? fpSrc1 : fpSrc2;
        end else begin
            minMax = minLess ? fpSrc2 : fpSrc1;
        end
    end

    always_comb begin
        intResult = '0;
        fpResult  = '0;
        flags     = '0;
        case (command)
            FpCmpCommand_Eq: begin
                intResult = {31'b0, equal && !anyNan};
                // Quiet comparison, only signaling NaNs raise invalid.
                flags.nv  = anySNan;
            end
            FpCmpCommand_Lt: begin
                intResult = {31'b0, less && !anyNan};
                flags.nv  = anyNan;
            end
            FpCmpCommand_Le: begin
                intResult = {31'b0, (less || equal) && !anyNan};
                flags.nv  = anyNan;
            end
            FpCmpCommand_Min, FpCmpCommand_Max: begin
                fpResult = minMax;
                flags.nv = anySNan;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: logic/Fp32Unit.sv
// Execution unit for the non-arithmetic single-precision instructions.
`timescale 1ns/1ps
`include "Fp32Unit_config.svh"

module Fp32Unit
    import Fp32Types::*;
(
    input  FpUnitCommand command,
    input  logic [31:0]  intSrc1,
    input  fp32_t        fpSrc1,
    input  fp32_t        fpSrc2,
    output logic [31:0]  intResult,
    output fp32_t        fpResult,
    output logic         writeFlags,
    output fflags_t      writeFlagsValue
);

    // Exactly one bit of the mask is set for every possible word.
    function automatic logic [9:0] getClass(fp32_t x);
        logic [9:0] mask;
        logic       expMax;
        logic       expZero;
        logic       fracZero;

        mask     = '0;
        expMax   = (x.field.exponent == 8'hff);
        expZero  = (x.field.exponent == 8'h00);
        fracZero = (x.field.fraction == '0);

        if (expMax && !fracZero) begin
            if (x.field.fraction[22]) mask[`FP_CLASS_QUIET_NAN] = 1'b1;
            else mask[`FP_CLASS_SIGNALING_NAN] = 1'b1;
        end else if (expMax) begin
            if (x.field.sign) mask[`FP_CLASS_NEG_INF] = 1'b1;
            else mask[`FP_CLASS_POS_INF] = 1'b1;
        end else if (expZero && fracZero) begin
            if (x.field.sign) mask[`FP_CLASS_NEG_ZERO] = 1'b1;
            else mask[`FP_CLASS_POS_ZERO] = 1'b1;
        end else if (expZero) begin
            if (x.field.sign) mask[`FP_CLASS_NEG_SUBNORMAL] = 1'b1;
            else mask[`FP_CLASS_POS_SUBNORMAL] = 1'b1;
        end else begin
            if (x.field.sign) mask[`FP_CLASS_NEG_NORMAL] = 1'b1;
            else mask[`FP_CLASS_POS_NORMAL] = 1'b1;
        end
        return mask;
    endfunction

    fp32_t       fpResultSign;
    logic [31:0] intResultCmp;
    fp32_t       fpResultCmp;
    fflags_t     flagsCmp;

    FpSignUnit u_FpSignUnit (
        .command (command.sign),
        .fpSrc1  (fpSrc1),
        .fpSrc2  (fpSrc2),
        .fpResult(fpResultSign)
    );

    FpComparator u_FpComparator (
        .command  (command.cmp),
        .fpSrc1   (fpSrc1),
        .fpSrc2   (fpSrc2),
        .intResult(intResultCmp),
        .fpResult (fpResultCmp),
        .flags    (flagsCmp)
    );

    always_comb begin
        intResult       = '0;
        fpResult        = '0;
        writeFlags      = 1'b0;
        writeFlagsValue = '0;
        case (command.unit)
            FpUnitType_Move: begin
                // FMV.X.W and FMV.W.X copy the bit pattern unchanged.
                intResult    = fpSrc1.raw;
                fpResult.raw = intSrc1;
            end
            FpUnitType_Classifier: begin
                intResult = {22'b0, getClass(fpSrc1)};
            end
            FpUnitType_Sign: begin
                fpResult = fpResultSign;
            end
            FpUnitType_Comparator: begin
                intResult       = intResultCmp;
                fpResult        = fpResultCmp;
                writeFlags      = 1'b1;
                writeFlagsValue = flagsCmp;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: logic/Fp32Coprocessor.sv
// Wishbone classic slave wrapping Fp32Unit with operand, command, result and flag registers.
`timescale 1ns/1ps
`include "Fp32Unit_config.svh"

module Fp32Coprocessor
    import Fp32Types::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  WbRequest  wbReq,
    output WbResponse wbRsp
);

    logic         ack;
    logic         access;
    logic         writeEn;
    logic         cmdWrite;
    logic [31:0]  readData;

    fp32_t        src1;
    fp32_t        src2;
    logic [31:0]  intSrc;
    FpUnitCommand commandReg;
    logic [31:0]  intRes;
    fp32_t        fpRes;
    fflags_t      accFlags;

    FpUnitCommand unitCommand;
    logic [31:0]  unitIntResult;
    fp32_t        unitFpResult;
    logic         unitWriteFlags;
    fflags_t      unitFlagsValue;

    // A new access is taken only when ack is low, so ack never lasts two cycles.
    assign access   = wbReq.cyc && wbReq.stb && !ack;
    assign writeEn  = access && wbReq.we;
    assign cmdWrite = writeEn && (wbReq.adr == `FP_REG_CMD);

    // The command being written is the one executed on its own acknowledging edge.
    assign unitCommand = cmdWrite ? FpUnitCommand'(wbReq.datW[6:0]) : commandReg;

    Fp32Unit u_Fp32Unit (
        .command        (unitCommand),
        .intSrc1        (intSrc),
        .fpSrc1         (src1),
        .fpSrc2         (src2),
        .intResult      (unitIntResult),
        .fpResult       (unitFpResult),
        .writeFlags     (unitWriteFlags),
        .writeFlagsValue(unitFlagsValue)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ack        <= 1'b0;
            src1       <= '0;
            src2       <= '0;
            intSrc     <= '0;
            commandReg <= '0;
            intRes     <= '0;
            fpRes      <= '0;
            accFlags   <= '0;
        end else begin
            ack <= access;
            if (writeEn) begin
                case (wbReq.adr)
                    `FP_REG_SRC1: begin
                        src1.raw <= wbReq.datW;
                    end
                    `FP_REG_SRC2: begin
                        src2.raw <= wbReq.datW;
                    end
                    `FP_REG_INTSRC: begin
                        intSrc <= wbReq.datW;
                    end
                    `FP_REG_CMD: begin
                        commandReg <= unitCommand;
                        intRes     <= unitIntResult;
                        fpRes      <= unitFpResult;
                        if (unitWriteFlags) begin
                            accFlags <= fflags_t'(accFlags | unitFlagsValue);
                        end
                    end
                    `FP_REG_FLAGS: begin
                        accFlags <= fflags_t'(wbReq.datW[4:0]);
                    end
                    default: begin
                        // Result registers are read-only and address 7 is unused.
                    end
                endcase
            end
        end
    end

    // The master holds adr until ack, so the mux output is stable while ack is high.
    always_comb begin
        case (wbReq.adr)
            `FP_REG_SRC1:   readData = src1.raw;
            `FP_REG_SRC2:   readData = src2.raw;
            `FP_REG_INTSRC: readData = intSrc;
            `FP_REG_CMD:    readData = {25'b0, commandReg};
            `FP_REG_INTRES: readData = intRes;
            `FP_REG_FPRES:  readData = fpRes.raw;
            `FP_REG_FLAGS:  readData = {27'b0, accFlags};
            default:        readData = '0;
        endcase
    end

    assign wbRsp.ack  = ack;
    assign wbRsp.datR = readData;

endmodule

// File: dv/Fp32Coprocessor_assert.sv
// Concurrent checks of the Wishbone ack handshake and the reset state of the coprocessor.
`timescale 1ns/1ps

module Fp32Coprocessor_assert
    import Fp32Types::*;
(
    input logic      clk,
    input logic      rstN,
    input WbRequest  wbReq,
    input WbResponse wbRsp
);

    int failCount = 0;

    // Ack is a single-cycle pulse.
    ackOneCycle: assert property (@(posedge clk) disable iff (!rstN)
        wbRsp.ack |=> !wbRsp.ack)
        else begin
            $error("ack held high for more than one cycle");
            failCount++;
        end

    ackAfterStrobe: assert property (@(posedge clk) disable iff (!rstN)
        wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb))
        else begin
            $error("ack raised without cyc and stb in the previous cycle");
            failCount++;
        end

    // Reset is asynchronous, so this is sampled on every clock edge it covers.
    ackLowInReset: assert property (@(posedge clk) !rstN |-> !wbRsp.ack)
        else begin
            $error("ack high while reset is asserted");
            failCount++;
        end

endmodule

bind Fp32Coprocessor Fp32Coprocessor_assert u_Fp32Coprocessor_assert (
    .clk  (clk),
    .rstN (rstN),
    .wbReq(wbReq),
    .wbRsp(wbRsp)
);

// File: dv/Fp32CoprocessorTb.sv
// Testbench for the Wishbone FP coprocessor that checks every read against a reference model.
`timescale 1ns/1ps
`include "Fp32Unit_config.svh"

module Fp32CoprocessorTb
    import Fp32Types::*;
();

    localparam int ackTimeout  = 20;
    localparam int numSpecials = 12;

    typedef struct packed {
        logic [31:0] intRes;
        logic [31:0] fpRes;
        fflags_t     flags;
        logic        setsFlags;
    } refResult_t;

    logic        clk;
    logic        rstN;
    WbRequest    wbReq;
    WbResponse   wbRsp;
    int          errorCount;
    int          checkCount;
    int          drainCycles;
    fflags_t     flagModel;
    logic [31:0] lastInt;
    logic [31:0] lastFp;
    logic [31:0] gotWord;
    logic [31:0] expWord;
    string       gotTag;
    logic [31:0] expQ [$];
    logic [31:0] gotQ [$];
    string       tagQ [$];

    Fp32Coprocessor u_Fp32Coprocessor (
        .clk  (clk),
        .rstN (rstN),
        .wbReq(wbReq),
        .wbRsp(wbRsp)
    );

    always #10 clk = ~clk;

    // Zeros, infinities, quiet and signaling NaNs, subnormals and plain normals.
    function automatic logic [31:0] specialValue(int k);
        case (k)
            0: return 32'h0000_0000;
            1: return 32'h8000_0000;
            2: return 32'h7f80_0000;
            3: return 32'hff80_0000;
            4: return 32'h7fc0_0000;
            5: return 32'hffc0_0000;
            6: return 32'h7f80_0001;
            7: return 32'hffa0_0000;
            8: return 32'h0000_0001;
            9: return 32'h807f_ffff;
            10: return 32'h3f80_0000;
            default: return 32'hbf80_0000;
        endcase
    endfunction

    function automatic logic [31:0] pickOperand();
        if ($urandom % 2 == 0) begin
            return specialValue($urandom % numSpecials);
        end
        return $urandom;
    endfunction

    function automatic FpUnitCommand makeCmd(FpUnitType unit, FpSignCommand sign,
                                             FpCmpCommand cmp);
        FpUnitCommand cmd;
        cmd.unit = unit;
        cmd.sign = sign;
        cmd.cmp  = cmp;
        return cmd;
    endfunction

    function automatic logic isNan(logic [31:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != 0);
    endfunction

    // Unsigned key that orders the words like their values, with minus zero below plus zero.
    function automatic logic [31:0] orderKey(logic [31:0] x);
        return x[31] ? ~x : (x | 32'h8000_0000);
    endfunction

    function automatic logic [9:0] classMask(logic [31:0] x);
        int idx;
        case (x[30:23])
            8'hff: begin
                if (x[22:0] == 0) idx = x[31] ? `FP_CLASS_NEG_INF : `FP_CLASS_POS_INF;
                else idx = x[22] ? `FP_CLASS_QUIET_NAN : `FP_CLASS_SIGNALING_NAN;
            end
            8'h00: begin
                if (x[22:0] == 0) idx = x[31] ? `FP_CLASS_NEG_ZERO : `FP_CLASS_POS_ZERO;
                else idx = x[31] ? `FP_CLASS_NEG_SUBNORMAL : `FP_CLASS_POS_SUBNORMAL;
            end
            default: idx = x[31] ? `FP_CLASS_NEG_NORMAL : `FP_CLASS_POS_NORMAL;
        endcase
        return 10'b1 << idx;
    endfunction

    function automatic refResult_t fpRefModel(FpUnitCommand cmd, logic [31:0] a,
                                              logic [31:0] b, logic [31:0] i);
        refResult_t r;
        logic       anyNan;
        logic       anySNan;
        logic       zeros;
        logic       sameValue;
        logic       lessThan;
        r         = '0;
        anyNan    = isNan(a) || isNan(b);
        anySNan   = (isNan(a) && !a[22]) || (isNan(b) && !b[22]);
        zeros     = (a[30:0] == 0) && (b[30:0] == 0);
        sameValue = (a == b) || zeros;
        lessThan  = (orderKey(a) < orderKey(b)) && !zeros;
        case (cmd.unit)
            FpUnitType_Move: begin
                r.intRes = a;
                r.fpRes  = i;
            end
            FpUnitType_Classifier: r.intRes = {22'b0, classMask(a)};
            FpUnitType_Sign: begin
                case (cmd.sign)
                    FpSignCommand_Sgnj:  r.fpRes = {b[31], a[30:0]};
                    FpSignCommand_Sgnjn: r.fpRes = {~b[31], a[30:0]};
                    default:             r.fpRes = {a[31] ^ b[31], a[30:0]};
                endcase
            end
            default: begin
                r.setsFlags = 1'b1;
                case (cmd.cmp)
                    FpCmpCommand_Eq: begin
                        r.intRes   = {31'b0, sameValue && !anyNan};
                        r.flags.nv = anySNan;
                    end
                    FpCmpCommand_Lt: begin
                        r.intRes   = {31'b0, lessThan && !anyNan};
                        r.flags.nv = anyNan;
                    end
                    FpCmpCommand_Le: begin
                        r.intRes   = {31'b0, (lessThan || sameValue) && !anyNan};
                        r.flags.nv = anyNan;
                    end
                    default: begin
                        if (isNan(a) && isNan(b)) r.fpRes = `FP_CANONICAL_NAN;
                        else if (isNan(a)) r.fpRes = b;
                        else if (isNan(b)) r.fpRes = a;
                        else if (cmd.cmp == FpCmpCommand_Min) begin
                            r.fpRes = (orderKey(a) < orderKey(b)) ? a : b;
                        end else begin
                            r.fpRes = (orderKey(a) < orderKey(b)) ? b : a;
                        end
                        r.flags.nv = anySNan;
                    end
                endcase
            end
        endcase
        return r;
    endfunction

    // One Wishbone classic access, started and ended on a falling edge.
    task automatic busAccess(input logic we, input logic [2:0] adr, input logic [31:0] data,
                             output logic [31:0] readBack);
        int waitCycles;
        waitCycles  = 0;
        wbReq.cyc   = 1'b1;
        wbReq.stb   = 1'b1;
        wbReq.we    = we;
        wbReq.adr   = adr;
        wbReq.datW  = data;
        @(negedge clk);
        while (!wbRsp.ack && waitCycles < ackTimeout) begin
            @(negedge clk);
            waitCycles++;
        end
        assert (wbRsp.ack) else begin
            $display("Error at %0t: no acknowledge from coprocessor", $time);
            errorCount++;
        end
        readBack = wbRsp.datR;
        wbReq    = '0;
    endtask

    task automatic wbWrite(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        busAccess(1'b1, adr, data, unused);
    endtask

    task automatic wbRead(input logic [2:0] adr, output logic [31:0] data);
        busAccess(1'b0, adr, 32'h0, data);
    endtask

    task automatic checkRead(input logic [2:0] adr, input logic [31:0] expected, input string tag);
        logic [31:0] data;
        wbRead(adr, data);
        gotQ.push_back(data);
        expQ.push_back(expected);
        tagQ.push_back(tag);
    endtask

    task automatic runOp(input FpUnitCommand cmd, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] i);
        refResult_t model;
        string      tag;
        model = fpRefModel(cmd, a, b, i);
        tag   = $sformatf("cmd %h src1 %h src2 %h", cmd, a, b);
        wbWrite(`FP_REG_SRC1, a);
        wbWrite(`FP_REG_SRC2, b);
        wbWrite(`FP_REG_INTSRC, i);
        wbWrite(`FP_REG_CMD, {25'b0, cmd});
        if (model.setsFlags) begin
            flagModel = fflags_t'(flagModel | model.flags);
        end
        lastInt = model.intRes;
        lastFp  = model.fpRes;
        checkRead(`FP_REG_INTRES, model.intRes, {tag, " intResult"});
        checkRead(`FP_REG_FPRES, model.fpRes, {tag, " fpResult"});
        checkRead(`FP_REG_FLAGS, {27'b0, flagModel}, {tag, " flags"});
    endtask

    // Reads are compared on the rising edge, away from the falling-edge stimulus.
    always @(posedge clk) begin
        while (expQ.size() > 0) begin
            gotWord = gotQ.pop_front();
            expWord = expQ.pop_front();
            gotTag  = tagQ.pop_front();
            checkCount++;
            assert (gotWord === expWord) else begin
                $display("Mismatch at %0t: %s read %h, expected %h",
                         $time, gotTag, gotWord, expWord);
                errorCount++;
            end
        end
    end

    initial begin
        FpUnitCommand cmd;
        clk        = 1'b0;
        rstN       = 1'b0;
        wbReq      = '0;
        errorCount = 0;
        checkCount = 0;
        flagModel  = '0;
        lastInt    = '0;
        lastFp     = '0;
        void'($urandom(32'ha5a1));
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        for (int r = 0; r < 8; r++) begin
            checkRead(r[2:0], 32'h0, "reset value");
        end

        for (int k = 0; k < numSpecials + 20; k++) begin
            cmd = makeCmd(FpUnitType_Move, FpSignCommand_Sgnj, FpCmpCommand_Eq);
            runOp(cmd, (k < numSpecials) ? specialValue(k) : pickOperand(), pickOperand(), $urandom);
            cmd = makeCmd(FpUnitType_Classifier, FpSignCommand_Sgnj, FpCmpCommand_Eq);
            runOp(cmd, (k < numSpecials) ? specialValue(k) : pickOperand(), pickOperand(), $urandom);
        end

        for (int s = 0; s < 3; s++) begin
            cmd = makeCmd(FpUnitType_Sign, FpSignCommand'(s), FpCmpCommand_Eq);
            repeat (24) begin
                runOp(cmd, pickOperand(), pickOperand(), $urandom);
            end
        end

        // Every pair of special values, then random mixes, for each comparison.
        wbWrite(`FP_REG_FLAGS, 32'h0);
        flagModel = '0;
        for (int c = 0; c < 5; c++) begin
            cmd = makeCmd(FpUnitType_Comparator, FpSignCommand_Sgnj, FpCmpCommand'(c));
            for (int j = 0; j < numSpecials; j++) begin
                for (int k = 0; k < numSpecials; k++) begin
                    runOp(cmd, specialValue(j), specialValue(k), $urandom);
                end
            end
            repeat (16) begin
                runOp(cmd, pickOperand(), pickOperand(), $urandom);
            end
        end

        wbWrite(`FP_REG_FLAGS, 32'hffff_ffea);
        flagModel = fflags_t'(5'h0a);
        checkRead(`FP_REG_FLAGS, {27'b0, flagModel}, "flags after write");
        cmd = makeCmd(FpUnitType_Sign, FpSignCommand_Sgnjx, FpCmpCommand_Eq);
        runOp(cmd, 32'h7f80_0001, 32'hffc0_0000, $urandom);
        cmd = makeCmd(FpUnitType_Comparator, FpSignCommand_Sgnj, FpCmpCommand_Lt);
        runOp(cmd, 32'h3f80_0000, 32'h7fc0_0000, $urandom);
        cmd = makeCmd(FpUnitType_Move, FpSignCommand_Sgnj, FpCmpCommand_Eq);
        runOp(cmd, 32'h4049_0fdb, 32'h0000_0000, 32'h5555_aaaa);

        // Operand writes alone and writes to read-only addresses leave the results alone.
        wbWrite(`FP_REG_SRC1, 32'h1234_5678);
        wbWrite(`FP_REG_SRC2, 32'h8765_4321);
        wbWrite(`FP_REG_INTSRC, 32'h0bad_f00d);
        checkRead(`FP_REG_INTRES, lastInt, "intResult after operand writes");
        checkRead(`FP_REG_FPRES, lastFp, "fpResult after operand writes");
        checkRead(`FP_REG_SRC1, 32'h1234_5678, "src1 readback");
        wbWrite(`FP_REG_INTRES, 32'hdead_beef);
        wbWrite(`FP_REG_FPRES, 32'hcafe_f00d);
        checkRead(`FP_REG_INTRES, lastInt, "intResult after read-only write");
        checkRead(`FP_REG_FPRES, lastFp, "fpResult after read-only write");
        wbWrite(3'd7, 32'hffff_ffff);
        checkRead(3'd7, 32'h0, "unused address");

        drainCycles = 0;
        while (expQ.size() != 0 && drainCycles < 8) begin
            @(posedge clk);
            drainCycles++;
        end
        assert (expQ.size() == 0) else begin
            $display("Error at %0t: some reads were never compared", $time);
            errorCount++;
        end
        errorCount += u_Fp32Coprocessor.u_Fp32Coprocessor_assert.failCount;
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: Fp32Coprocessor.f
+incdir+logic
logic/Fp32Types.sv
logic/FpSignUnit.sv
logic/FpComparator.sv
logic/Fp32Unit.sv
logic/Fp32Coprocessor.sv
dv/Fp32Coprocessor_assert.sv
dv/Fp32CoprocessorTb.sv

// File: Bender.yml
package:
  name: Fp32Coprocessor

sources:
  - include_dirs:
      - logic
    files:
      - logic/Fp32Types.sv
      - logic/FpSignUnit.sv
      - logic/FpComparator.sv
      - logic/Fp32Unit.sv
      - logic/Fp32Coprocessor.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/Fp32Coprocessor_assert.sv
      - dv/Fp32CoprocessorTb.sv
